// File: mem_byte_lane.sv
module mem_byte_lane #(
  parameter int WORD_ADDR_BITS = 13
) (
  input  logic                             clk,

  // instruction side, read only
  input  logic [WORD_ADDR_BITS-1:0]        inst_idx_i,
  input  logic                             inst_rd_en_i,

  // data side, read and write
  input  logic [WORD_ADDR_BITS-1:0]        data_idx_i,
  input  logic                             data_we_i,
  input  logic                             data_rd_en_i,
  input  logic [mem_pkg::LANE_WIDTH-1:0]   data_byte_i,

  // registered, masked read bytes
  output logic [mem_pkg::LANE_WIDTH-1:0]   inst_byte_o,
  output logic [mem_pkg::LANE_WIDTH-1:0]   data_byte_o
);

  localparam int DEPTH = 2 ** WORD_ADDR_BITS;

  // one byte of every word, contents undefined at start
  logic [mem_pkg::LANE_WIDTH-1:0] mem_q [DEPTH];

  // write port, commits at the edge
  always_ff @(posedge clk)
  begin
    if (data_we_i)
    begin
      mem_q[data_idx_i] <= data_byte_i;
    end
  end

  // both reads sample the array before the write lands
  // so a same-cycle read sees the old byte
  always_ff @(posedge clk)
  begin
    if (inst_rd_en_i)
    begin
      inst_byte_o <= mem_q[inst_idx_i];
    end
    else
    begin
      // unselected or idle lane reads as zero
      inst_byte_o <= '0;
    end

    if (data_rd_en_i)
    begin
      data_byte_o <= mem_q[data_idx_i];
    end
    else
    begin
      data_byte_o <= '0;
    end
  end

endmodule

// File: mem_dual_port.sv
module mem_dual_port #(
  parameter int WORD_ADDR_BITS = 13
) (
  input  logic                             clk,
  input  logic                             reset_i,

  // instruction port, fetch only
  input  logic                             inst_cyc_i,
  input  logic                             inst_stb_i,
  input  logic [mem_pkg::ADR_WIDTH-1:0]    inst_adr_i,
  input  logic [mem_pkg::LANE_COUNT-1:0]   inst_sel_i,
  input  logic [mem_pkg::TGA_WIDTH-1:0]    inst_tga_i,
  input  logic [mem_pkg::TGD_WIDTH-1:0]    inst_tgd_i,
  input  logic [mem_pkg::TGC_WIDTH-1:0]    inst_tgc_i,
  output logic                             inst_ack_o,
  output logic [mem_pkg::DATA_WIDTH-1:0]   inst_dat_o,
  output logic [mem_pkg::TGA_WIDTH-1:0]    inst_tga_o,
  output logic [mem_pkg::TGD_WIDTH-1:0]    inst_tgd_o,
  output logic [mem_pkg::TGC_WIDTH-1:0]    inst_tgc_o,

  // data port, read and byte-masked write
  input  logic                             data_cyc_i,
  input  logic                             data_stb_i,
  input  logic                             data_we_i,
  input  logic [mem_pkg::ADR_WIDTH-1:0]    data_adr_i,
  input  logic [mem_pkg::LANE_COUNT-1:0]   data_sel_i,
  input  logic [mem_pkg::DATA_WIDTH-1:0]   data_dat_i,
  input  logic [mem_pkg::TGA_WIDTH-1:0]    data_tga_i,
  input  logic [mem_pkg::TGD_WIDTH-1:0]    data_tgd_i,
  input  logic [mem_pkg::TGC_WIDTH-1:0]    data_tgc_i,
  output logic                             data_ack_o,
  output logic [mem_pkg::DATA_WIDTH-1:0]   data_dat_o,
  output logic [mem_pkg::TGA_WIDTH-1:0]    data_tga_o,
  output logic [mem_pkg::TGD_WIDTH-1:0]    data_tgd_o,
  output logic [mem_pkg::TGC_WIDTH-1:0]    data_tgc_o
);

  // decoder outputs
  logic [WORD_ADDR_BITS-1:0]      inst_idx;
  logic [WORD_ADDR_BITS-1:0]      data_idx;
  logic [mem_pkg::LANE_COUNT-1:0] lane_we;
  logic [mem_pkg::LANE_COUNT-1:0] inst_rd_en;
  logic [mem_pkg::LANE_COUNT-1:0] data_rd_en;
  logic                           inst_req;
  logic                           data_req;

  // lane read bytes into the collector
  logic [mem_pkg::LANE_COUNT-1:0][mem_pkg::LANE_WIDTH-1:0] inst_lane_bytes;
  logic [mem_pkg::LANE_COUNT-1:0][mem_pkg::LANE_WIDTH-1:0] data_lane_bytes;

  // request split into indices and lane strobes
  mem_port_decode #(
    .WORD_ADDR_BITS (WORD_ADDR_BITS)
  ) u_decode (
    .inst_cyc_i   (inst_cyc_i),
    .inst_stb_i   (inst_stb_i),
    .inst_adr_i   (inst_adr_i),
    .inst_sel_i   (inst_sel_i),
    .data_cyc_i   (data_cyc_i),
    .data_stb_i   (data_stb_i),
    .data_we_i    (data_we_i),
    .data_adr_i   (data_adr_i),
    .data_sel_i   (data_sel_i),
    .inst_idx_o   (inst_idx),
    .data_idx_o   (data_idx),
    .lane_we_o    (lane_we),
    .inst_rd_en_o (inst_rd_en),
    .data_rd_en_o (data_rd_en),
    .inst_req_o   (inst_req),
    .data_req_o   (data_req)
  );

  // one bank per byte lane, data byte k feeds lane k
  for (genvar k = 0; k < mem_pkg::LANE_COUNT; k++)
  begin : g_lane
    mem_byte_lane #(
      .WORD_ADDR_BITS (WORD_ADDR_BITS)
    ) u_lane (
      .clk          (clk),
      .inst_idx_i   (inst_idx),
      .inst_rd_en_i (inst_rd_en[k]),
      .data_idx_i   (data_idx),
      .data_we_i    (lane_we[k]),
      .data_rd_en_i (data_rd_en[k]),
      .data_byte_i  (data_dat_i[k*mem_pkg::LANE_WIDTH +: mem_pkg::LANE_WIDTH]),
      .inst_byte_o  (inst_lane_bytes[k]),
      .data_byte_o  (data_lane_bytes[k])
    );
  end

  // acks, tags and word assembly
  mem_rsp_collect u_collect (
    .clk               (clk),
    .reset_i           (reset_i),
    .inst_req_i        (inst_req),
    .data_req_i        (data_req),
    .inst_tga_i        (inst_tga_i),
    .inst_tgd_i        (inst_tgd_i),
    .inst_tgc_i        (inst_tgc_i),
    .data_tga_i        (data_tga_i),
    .data_tgd_i        (data_tgd_i),
    .data_tgc_i        (data_tgc_i),
    .inst_lane_bytes_i (inst_lane_bytes),
    .data_lane_bytes_i (data_lane_bytes),
    .inst_ack_o        (inst_ack_o),
    .inst_dat_o        (inst_dat_o),
    .inst_tga_o        (inst_tga_o),
    .inst_tgd_o        (inst_tgd_o),
    .inst_tgc_o        (inst_tgc_o),
    .data_ack_o        (data_ack_o),
    .data_dat_o        (data_dat_o),
    .data_tga_o        (data_tga_o),
    .data_tgd_o        (data_tgd_o),
    .data_tgc_o        (data_tgc_o)
  );

endmodule

// File: mem_pkg.sv
package mem_pkg;

  // bus data word
  localparam int DATA_WIDTH = 32;

  // one byte lane per sel bit
  localparam int LANE_WIDTH = 8;
  localparam int LANE_COUNT = DATA_WIDTH / LANE_WIDTH;

  // byte address on the bus
  localparam int ADR_WIDTH = 32;

  // low address bits below the word index
  localparam int BYTE_OFS_BITS = 2;

  // tag widths, echoed back with the ack
  localparam int TGA_WIDTH = 4;
  localparam int TGD_WIDTH = 4;
  localparam int TGC_WIDTH = 4;

endpackage

// File: mem_port_decode.sv
module mem_port_decode #(
  parameter int WORD_ADDR_BITS = 13
) (
  // instruction port request, read only
  input  logic                             inst_cyc_i,
  input  logic                             inst_stb_i,
  input  logic [mem_pkg::ADR_WIDTH-1:0]    inst_adr_i,
  input  logic [mem_pkg::LANE_COUNT-1:0]   inst_sel_i,

  // data port request
  input  logic                             data_cyc_i,
  input  logic                             data_stb_i,
  input  logic                             data_we_i,
  input  logic [mem_pkg::ADR_WIDTH-1:0]    data_adr_i,
  input  logic [mem_pkg::LANE_COUNT-1:0]   data_sel_i,

  // word indices shared by all lanes
  output logic [WORD_ADDR_BITS-1:0]        inst_idx_o,
  output logic [WORD_ADDR_BITS-1:0]        data_idx_o,

  // per-lane strobes
  output logic [mem_pkg::LANE_COUNT-1:0]   lane_we_o,
  output logic [mem_pkg::LANE_COUNT-1:0]   inst_rd_en_o,
  output logic [mem_pkg::LANE_COUNT-1:0]   data_rd_en_o,

  // request strobes to the collector
  output logic                             inst_req_o,
  output logic                             data_req_o
);

  logic inst_req;
  logic data_req;
  logic data_wr;

  // a request is any cycle with cyc and stb both high
  assign inst_req = inst_cyc_i & inst_stb_i;
  assign data_req = data_cyc_i & data_stb_i;

  // write only on a real data-port request
  assign data_wr = data_req & data_we_i;

  // word index sits just above the byte offset
  // upper address bits dropped, so the space wraps
  assign inst_idx_o = inst_adr_i[mem_pkg::BYTE_OFS_BITS +: WORD_ADDR_BITS];
  assign data_idx_o = data_adr_i[mem_pkg::BYTE_OFS_BITS +: WORD_ADDR_BITS];

  // byte-masked write enables, one bit per lane
  assign lane_we_o = {mem_pkg::LANE_COUNT{data_wr}} & data_sel_i;

  // read enables follow sel for any request
  // a data write still returns the old word (read-first)
  assign inst_rd_en_o = {mem_pkg::LANE_COUNT{inst_req}} & inst_sel_i;
  assign data_rd_en_o = {mem_pkg::LANE_COUNT{data_req}} & data_sel_i;

  // collector registers these into the acks
  assign inst_req_o = inst_req;
  assign data_req_o = data_req;

endmodule

// File: mem_rsp_collect.sv
module mem_rsp_collect (
  input  logic                                                  clk,
  input  logic                                                  reset_i,

  // request strobes from the decoder
  input  logic                                                  inst_req_i,
  input  logic                                                  data_req_i,

  // tags straight from the bus
  input  logic [mem_pkg::TGA_WIDTH-1:0]                         inst_tga_i,
  input  logic [mem_pkg::TGD_WIDTH-1:0]                         inst_tgd_i,
  input  logic [mem_pkg::TGC_WIDTH-1:0]                         inst_tgc_i,
  input  logic [mem_pkg::TGA_WIDTH-1:0]                         data_tga_i,
  input  logic [mem_pkg::TGD_WIDTH-1:0]                         data_tgd_i,
  input  logic [mem_pkg::TGC_WIDTH-1:0]                         data_tgc_i,

  // registered bytes, lane k at index k
  input  logic [mem_pkg::LANE_COUNT-1:0][mem_pkg::LANE_WIDTH-1:0] inst_lane_bytes_i,
  input  logic [mem_pkg::LANE_COUNT-1:0][mem_pkg::LANE_WIDTH-1:0] data_lane_bytes_i,

  // instruction port response
  output logic                                                  inst_ack_o,
  output logic [mem_pkg::DATA_WIDTH-1:0]                        inst_dat_o,
  output logic [mem_pkg::TGA_WIDTH-1:0]                         inst_tga_o,
  output logic [mem_pkg::TGD_WIDTH-1:0]                         inst_tgd_o,
  output logic [mem_pkg::TGC_WIDTH-1:0]                         inst_tgc_o,

  // data port response
  output logic                                                  data_ack_o,
  output logic [mem_pkg::DATA_WIDTH-1:0]                        data_dat_o,
  output logic [mem_pkg::TGA_WIDTH-1:0]                         data_tga_o,
  output logic [mem_pkg::TGD_WIDTH-1:0]                         data_tgd_o,
  output logic [mem_pkg::TGC_WIDTH-1:0]                         data_tgc_o
);

  // acks, one cycle after the request
  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      inst_ack_o <= 1'b0;
      data_ack_o <= 1'b0;
    end
    else
    begin
      inst_ack_o <= inst_req_i;
      data_ack_o <= data_req_i;
    end
  end

  // tags delayed to line up with the lane read data
  always_ff @(posedge clk)
  begin
    inst_tga_o <= inst_tga_i;
    inst_tgd_o <= inst_tgd_i;
    inst_tgc_o <= inst_tgc_i;
    data_tga_o <= data_tga_i;
    data_tgd_o <= data_tgd_i;
    data_tgc_o <= data_tgc_i;
  end

  // lane k lands on bits 8k+7 downto 8k
  always_comb
  begin
    for (int k = 0; k < mem_pkg::LANE_COUNT; k++)
    begin
      inst_dat_o[k*mem_pkg::LANE_WIDTH +: mem_pkg::LANE_WIDTH] = inst_lane_bytes_i[k];
      data_dat_o[k*mem_pkg::LANE_WIDTH +: mem_pkg::LANE_WIDTH] = data_lane_bytes_i[k];
    end
  end

endmodule

// File: mem_tb.sv
module mem_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WORD_BITS = 6;
  localparam int DEPTH = 2 ** WORD_BITS;
  localparam int RESET_TIMEOUT = 20;

  // one table row, both ports plus a data check flag
  typedef struct packed {
    logic                           d_cyc;
    logic                           d_stb;
    logic                           d_we;
    logic [mem_pkg::ADR_WIDTH-1:0]  d_adr;
    logic [mem_pkg::LANE_COUNT-1:0] d_sel;
    logic [mem_pkg::DATA_WIDTH-1:0] d_dat;
    logic [mem_pkg::TGA_WIDTH-1:0]  d_tga;
    logic [mem_pkg::TGD_WIDTH-1:0]  d_tgd;
    logic [mem_pkg::TGC_WIDTH-1:0]  d_tgc;
    logic                           i_cyc;
    logic                           i_stb;
    logic [mem_pkg::ADR_WIDTH-1:0]  i_adr;
    logic [mem_pkg::LANE_COUNT-1:0] i_sel;
    logic [mem_pkg::TGA_WIDTH-1:0]  i_tga;
    logic [mem_pkg::TGD_WIDTH-1:0]  i_tgd;
    logic [mem_pkg::TGC_WIDTH-1:0]  i_tgc;
    logic                           check;
  } op_t;

  logic clk = 1'b0;
  logic reset_i = 1'b1;

  logic                           inst_cyc_i;
  logic                           inst_stb_i;
  logic [mem_pkg::ADR_WIDTH-1:0]  inst_adr_i;
  logic [mem_pkg::LANE_COUNT-1:0] inst_sel_i;
  logic [mem_pkg::TGA_WIDTH-1:0]  inst_tga_i;
  logic [mem_pkg::TGD_WIDTH-1:0]  inst_tgd_i;
  logic [mem_pkg::TGC_WIDTH-1:0]  inst_tgc_i;
  logic                           inst_ack_o;
  logic [mem_pkg::DATA_WIDTH-1:0] inst_dat_o;
  logic [mem_pkg::TGA_WIDTH-1:0]  inst_tga_o;
  logic [mem_pkg::TGD_WIDTH-1:0]  inst_tgd_o;
  logic [mem_pkg::TGC_WIDTH-1:0]  inst_tgc_o;

  logic                           data_cyc_i;
  logic                           data_stb_i;
  logic                           data_we_i;
  logic [mem_pkg::ADR_WIDTH-1:0]  data_adr_i;
  logic [mem_pkg::LANE_COUNT-1:0] data_sel_i;
  logic [mem_pkg::DATA_WIDTH-1:0] data_dat_i;
  logic [mem_pkg::TGA_WIDTH-1:0]  data_tga_i;
  logic [mem_pkg::TGD_WIDTH-1:0]  data_tgd_i;
  logic [mem_pkg::TGC_WIDTH-1:0]  data_tgc_i;
  logic                           data_ack_o;
  logic [mem_pkg::DATA_WIDTH-1:0] data_dat_o;
  logic [mem_pkg::TGA_WIDTH-1:0]  data_tga_o;
  logic [mem_pkg::TGD_WIDTH-1:0]  data_tgd_o;
  logic [mem_pkg::TGC_WIDTH-1:0]  data_tgc_o;

  // stimulus table and the row being built
  op_t ops[$];
  op_t stage;
  op_t idle_op;

  // reference copy of the memory, word then lane
  logic [mem_pkg::LANE_WIDTH-1:0] shadow [DEPTH][mem_pkg::LANE_COUNT];

  // response expected after the next edge
  op_t                            exp_op;
  logic                           exp_i_ack;
  logic                           exp_d_ack;
  logic [mem_pkg::DATA_WIDTH-1:0] exp_i_dat;
  logic [mem_pkg::DATA_WIDTH-1:0] exp_d_dat;
  int                             exp_entry;

  logic [31:0] lcg_state = 32'd53655;
  int check_count = 0;
  int error_count = 0;
  int reset_wait;

  mem_dual_port #(
    .WORD_ADDR_BITS (WORD_BITS)
  ) u_mem_dual_port (
    .clk        (clk),
    .reset_i    (reset_i),
    .inst_cyc_i (inst_cyc_i),
    .inst_stb_i (inst_stb_i),
    .inst_adr_i (inst_adr_i),
    .inst_sel_i (inst_sel_i),
    .inst_tga_i (inst_tga_i),
    .inst_tgd_i (inst_tgd_i),
    .inst_tgc_i (inst_tgc_i),
    .inst_ack_o (inst_ack_o),
    .inst_dat_o (inst_dat_o),
    .inst_tga_o (inst_tga_o),
    .inst_tgd_o (inst_tgd_o),
    .inst_tgc_o (inst_tgc_o),
    .data_cyc_i (data_cyc_i),
    .data_stb_i (data_stb_i),
    .data_we_i  (data_we_i),
    .data_adr_i (data_adr_i),
    .data_sel_i (data_sel_i),
    .data_dat_i (data_dat_i),
    .data_tga_i (data_tga_i),
    .data_tgd_i (data_tgd_i),
    .data_tgc_i (data_tgc_i),
    .data_ack_o (data_ack_o),
    .data_dat_o (data_dat_o),
    .data_tga_o (data_tga_o),
    .data_tgd_o (data_tgd_o),
    .data_tgc_o (data_tgc_o)
  );

  bind mem_dual_port mem_tb_assertions u_assertions (
    .clk        (clk),
    .reset_i    (reset_i),
    .inst_cyc_i (inst_cyc_i),
    .inst_stb_i (inst_stb_i),
    .inst_tga_i (inst_tga_i),
    .inst_tgd_i (inst_tgd_i),
    .inst_tgc_i (inst_tgc_i),
    .inst_ack_o (inst_ack_o),
    .inst_tga_o (inst_tga_o),
    .inst_tgd_o (inst_tgd_o),
    .inst_tgc_o (inst_tgc_o),
    .data_cyc_i (data_cyc_i),
    .data_stb_i (data_stb_i),
    .data_tga_i (data_tga_i),
    .data_tgd_i (data_tgd_i),
    .data_tgc_i (data_tgc_i),
    .data_ack_o (data_ack_o),
    .data_tga_o (data_tga_o),
    .data_tgd_o (data_tgd_o),
    .data_tgc_o (data_tgc_o)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // reset held for 4 rising edges, bus goes idle as it drops
  initial
  begin
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;
    drive_op(idle_op);
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] word_adr(int idx);
    return 32'(idx) << mem_pkg::BYTE_OFS_BITS;
  endfunction

  // initial contents, every byte tied to the word index
  function automatic logic [31:0] fill_word(int idx);
    logic [7:0] b;
    b = 8'(idx);
    return {b ^ 8'hc3, b * 8'd7, ~b, b};
  endfunction

  // fresh idle row with random tags on both ports
  task automatic begin_entry();
    logic [31:0] r;
    r = lcg_next();
    stage = '0;
    stage.d_tga = r[31:28];
    stage.d_tgd = r[27:24];
    stage.d_tgc = r[23:20];
    stage.i_tga = r[19:16];
    stage.i_tgd = r[15:12];
    stage.i_tgc = r[11:8];
  endtask

  task automatic data_request(logic we, logic [31:0] adr, logic [3:0] sel, logic [31:0] dat);
    stage.d_cyc = 1'b1;
    stage.d_stb = 1'b1;
    stage.d_we  = we;
    stage.d_adr = adr;
    stage.d_sel = sel;
    stage.d_dat = dat;
  endtask

  task automatic inst_request(logic [31:0] adr, logic [3:0] sel);
    stage.i_cyc = 1'b1;
    stage.i_stb = 1'b1;
    stage.i_adr = adr;
    stage.i_sel = sel;
  endtask

  task automatic append_entry(logic check);
    stage.check = check;
    ops.push_back(stage);
  endtask

  task automatic build_table();
    logic [31:0] r;
    // known contents everywhere, old data unchecked
    for (int i = 0; i < DEPTH; i++)
    begin
      begin_entry();
      data_request(1'b1, word_adr(i), 4'hf, fill_word(i));
      append_entry(1'b0);
    end
    // cyc without stb, stb without cyc, then fully idle
    begin_entry();
    data_request(1'b1, word_adr(3), 4'hf, 32'hdead_beef);
    stage.d_stb = 1'b0;
    inst_request(word_adr(3), 4'hf);
    stage.i_cyc = 1'b0;
    append_entry(1'b1);
    begin_entry();
    data_request(1'b0, word_adr(5), 4'hf, 32'h0);
    stage.d_cyc = 1'b0;
    append_entry(1'b1);
    begin_entry();
    append_entry(1'b1);
    // fill read back, word 3 first on the inst port
    for (int i = 0; i < 8; i++)
    begin
      begin_entry();
      data_request(1'b0, word_adr((i * 9) % DEPTH), 4'hf, 32'h0);
      inst_request(word_adr((i * 5 + 3) % DEPTH), 4'hf);
      append_entry(1'b1);
    end
    // full words, then both ports read them back
    for (int i = 0; i < 2; i++)
    begin
      begin_entry();
      data_request(1'b1, word_adr(10 + 53 * i), 4'hf, lcg_next());
      append_entry(1'b1);
      begin_entry();
      data_request(1'b0, word_adr(10 + 53 * i), 4'hf, 32'h0);
      inst_request(word_adr(10 + 53 * i), 4'hf);
      append_entry(1'b1);
    end
    // byte-masked writes to word 20
    begin_entry();
    data_request(1'b1, word_adr(20), 4'b0001, lcg_next());
    append_entry(1'b1);
    begin_entry();
    data_request(1'b1, word_adr(20), 4'b0100, lcg_next());
    append_entry(1'b1);
    begin_entry();
    data_request(1'b1, word_adr(20), 4'b1010, lcg_next());
    append_entry(1'b1);
    begin_entry();
    data_request(1'b0, word_adr(20), 4'hf, 32'h0);
    inst_request(word_adr(20), 4'hf);
    append_entry(1'b1);
    // partial reads, zero in unselected lanes
    begin_entry();
    data_request(1'b0, word_adr(20), 4'b0110, 32'h0);
    inst_request(word_adr(20), 4'b1001);
    append_entry(1'b1);
    begin_entry();
    data_request(1'b0, word_adr(20), 4'b0000, 32'h0);
    inst_request(word_adr(21), 4'b0010);
    append_entry(1'b1);
    // same-cycle write and reads give the old word
    begin_entry();
    data_request(1'b1, word_adr(30), 4'hf, lcg_next());
    inst_request(word_adr(30), 4'hf);
    append_entry(1'b1);
    begin_entry();
    data_request(1'b0, word_adr(30), 4'hf, 32'h0);
    inst_request(word_adr(30), 4'hf);
    append_entry(1'b1);
    begin_entry();
    data_request(1'b1, word_adr(31), 4'b0011, lcg_next());
    inst_request(word_adr(31), 4'hf);
    append_entry(1'b1);
    begin_entry();
    data_request(1'b0, word_adr(31), 4'hf, 32'h0);
    inst_request(word_adr(31), 4'hf);
    append_entry(1'b1);
    // aliases above the index and in the byte offset
    begin_entry();
    data_request(1'b1, word_adr(40) | 32'h0010_0003, 4'hf, lcg_next());
    append_entry(1'b1);
    begin_entry();
    data_request(1'b0, word_adr(40) | 32'h8000_0001, 4'hf, 32'h0);
    inst_request(word_adr(40) + word_adr(DEPTH), 4'hf);
    append_entry(1'b1);
    // random back-to-back traffic, wrapped addresses
    for (int n = 0; n < 24; n++)
    begin
      begin_entry();
      r = lcg_next();
      data_request(r[27], lcg_next(), r[23:20], lcg_next());
      stage.d_cyc = r[31] | r[30];
      stage.d_stb = r[29] | r[28];
      inst_request(lcg_next(), r[19:16]);
      stage.i_cyc = r[26] | r[25];
      stage.i_stb = r[24] | r[15];
      append_entry(1'b1);
    end
    begin_entry();
    append_entry(1'b1);
  endtask

  task drive_op(input op_t e);
    data_cyc_i <= e.d_cyc;
    data_stb_i <= e.d_stb;
    data_we_i  <= e.d_we;
    data_adr_i <= e.d_adr;
    data_sel_i <= e.d_sel;
    data_dat_i <= e.d_dat;
    data_tga_i <= e.d_tga;
    data_tgd_i <= e.d_tgd;
    data_tgc_i <= e.d_tgc;
    inst_cyc_i <= e.i_cyc;
    inst_stb_i <= e.i_stb;
    inst_adr_i <= e.i_adr;
    inst_sel_i <= e.i_sel;
    inst_tga_i <= e.i_tga;
    inst_tgd_i <= e.i_tgd;
    inst_tgc_i <= e.i_tgc;
  endtask

  // expected response, then the write applied to the shadow
  task automatic predict(input op_t e, input int entry);
    logic [WORD_BITS-1:0] d_idx;
    logic [WORD_BITS-1:0] i_idx;
    d_idx = e.d_adr[mem_pkg::BYTE_OFS_BITS +: WORD_BITS];
    i_idx = e.i_adr[mem_pkg::BYTE_OFS_BITS +: WORD_BITS];
    exp_op = e;
    exp_entry = entry;
    exp_d_ack = e.d_cyc & e.d_stb;
    exp_i_ack = e.i_cyc & e.i_stb;
    for (int k = 0; k < mem_pkg::LANE_COUNT; k++)
    begin
      exp_d_dat[k*mem_pkg::LANE_WIDTH +: mem_pkg::LANE_WIDTH] =
        e.d_sel[k] ? shadow[d_idx][k] : 8'h00;
      exp_i_dat[k*mem_pkg::LANE_WIDTH +: mem_pkg::LANE_WIDTH] =
        e.i_sel[k] ? shadow[i_idx][k] : 8'h00;
    end
    // read-first, the new bytes show from the next request on
    if (exp_d_ack && e.d_we)
    begin
      for (int k = 0; k < mem_pkg::LANE_COUNT; k++)
      begin
        if (e.d_sel[k])
        begin
          shadow[d_idx][k] = e.d_dat[k*mem_pkg::LANE_WIDTH +: mem_pkg::LANE_WIDTH];
        end
      end
    end
  endtask

  task automatic compare_field(string what, logic [31:0] got, logic [31:0] want);
    check_count++;
    if (got !== want)
    begin
      $display("Fail %0t: %s is %h, expected %h (table entry %0d)",
               $time, what, got, want, exp_entry);
      error_count++;
    end
  endtask

  task automatic check_pending();
    compare_field("inst_ack_o", 32'(inst_ack_o), 32'(exp_i_ack));
    compare_field("data_ack_o", 32'(data_ack_o), 32'(exp_d_ack));
    if (exp_i_ack)
    begin
      compare_field("inst_tga_o", 32'(inst_tga_o), 32'(exp_op.i_tga));
      compare_field("inst_tgd_o", 32'(inst_tgd_o), 32'(exp_op.i_tgd));
      compare_field("inst_tgc_o", 32'(inst_tgc_o), 32'(exp_op.i_tgc));
      if (exp_op.check)
      begin
        compare_field("inst_dat_o", inst_dat_o, exp_i_dat);
      end
    end
    if (exp_d_ack)
    begin
      compare_field("data_tga_o", 32'(data_tga_o), 32'(exp_op.d_tga));
      compare_field("data_tgd_o", 32'(data_tgd_o), 32'(exp_op.d_tgd));
      compare_field("data_tgc_o", 32'(data_tgc_o), 32'(exp_op.d_tgc));
      if (exp_op.check)
      begin
        compare_field("data_dat_o", data_dat_o, exp_d_dat);
      end
    end
  endtask

  initial
  begin
    idle_op = '0;
    // read requests on both ports all through reset
    begin_entry();
    data_request(1'b0, word_adr(0), 4'hf, 32'h0);
    inst_request(word_adr(0), 4'hf);
    drive_op(stage);
    exp_op = '0;
    exp_i_ack = 1'b0;
    exp_d_ack = 1'b0;
    exp_entry = -1;
    build_table();
    reset_wait = 0;
    while (reset_i !== 1'b0 && reset_wait < RESET_TIMEOUT)
    begin
      @(negedge clk);
      reset_wait++;
    end
    if (reset_i !== 1'b0)
    begin
      $display("reset_i still high after %0d cycles, run stopped", reset_wait);
      $display("*** TEST FAILED ***");
    end
    else
    begin
      // requests were held, reset alone keeps both acks low
      compare_field("inst_ack_o after reset", 32'(inst_ack_o), 32'h0);
      compare_field("data_ack_o after reset", 32'(data_ack_o), 32'h0);
      // row i driven, row i-1 checked one edge later
      for (int i = 0; i < ops.size(); i++)
      begin
        @(posedge clk);
        drive_op(ops[i]);
        @(negedge clk);
        check_pending();
        predict(ops[i], i);
      end
      @(posedge clk);
      drive_op(idle_op);
      @(negedge clk);
      check_pending();
      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0)
      begin
        $display("*** TEST PASSED ***");
      end
      else
      begin
        $display("*** TEST FAILED ***");
      end
    end
    $finish;
  end

endmodule

// File: mem_tb_assertions.sv
module mem_tb_assertions (
  input logic                           clk,
  input logic                           reset_i,
  input logic                           inst_cyc_i,
  input logic                           inst_stb_i,
  input logic [mem_pkg::TGA_WIDTH-1:0]  inst_tga_i,
  input logic [mem_pkg::TGD_WIDTH-1:0]  inst_tgd_i,
  input logic [mem_pkg::TGC_WIDTH-1:0]  inst_tgc_i,
  input logic                           inst_ack_o,
  input logic [mem_pkg::TGA_WIDTH-1:0]  inst_tga_o,
  input logic [mem_pkg::TGD_WIDTH-1:0]  inst_tgd_o,
  input logic [mem_pkg::TGC_WIDTH-1:0]  inst_tgc_o,
  input logic                           data_cyc_i,
  input logic                           data_stb_i,
  input logic [mem_pkg::TGA_WIDTH-1:0]  data_tga_i,
  input logic [mem_pkg::TGD_WIDTH-1:0]  data_tgd_i,
  input logic [mem_pkg::TGC_WIDTH-1:0]  data_tgc_i,
  input logic                           data_ack_o,
  input logic [mem_pkg::TGA_WIDTH-1:0]  data_tga_o,
  input logic [mem_pkg::TGD_WIDTH-1:0]  data_tgd_o,
  input logic [mem_pkg::TGC_WIDTH-1:0]  data_tgc_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // ack high exactly in the cycle after a request
  a_inst_ack: assert property (@(posedge clk) disable iff (reset_i)
    (inst_cyc_i && inst_stb_i) |=> inst_ack_o)
    else $error("inst_ack_o missing after a request");
  a_inst_idle: assert property (@(posedge clk) disable iff (reset_i)
    !(inst_cyc_i && inst_stb_i) |=> !inst_ack_o)
    else $error("inst_ack_o high without a request");
  a_data_ack: assert property (@(posedge clk) disable iff (reset_i)
    (data_cyc_i && data_stb_i) |=> data_ack_o)
    else $error("data_ack_o missing after a request");
  a_data_idle: assert property (@(posedge clk) disable iff (reset_i)
    !(data_cyc_i && data_stb_i) |=> !data_ack_o)
    else $error("data_ack_o high without a request");

  // reset clears both acks
  a_reset_ack: assert property (@(posedge clk) reset_i |=> (!inst_ack_o && !data_ack_o))
    else $error("ack high in the cycle after reset");

  // tags come back with the ack, unchanged
  a_inst_tags: assert property (@(posedge clk) disable iff (reset_i)
    (inst_cyc_i && inst_stb_i) |=> (inst_tga_o == $past(inst_tga_i) &&
    inst_tgd_o == $past(inst_tgd_i) && inst_tgc_o == $past(inst_tgc_i)))
    else $error("inst tags differ from the request");
  a_data_tags: assert property (@(posedge clk) disable iff (reset_i)
    (data_cyc_i && data_stb_i) |=> (data_tga_o == $past(data_tga_i) &&
    data_tgd_o == $past(data_tgd_i) && data_tgc_o == $past(data_tgc_i)))
    else $error("data tags differ from the request");

endmodule

// File: project.f
mem_pkg.sv
mem_port_decode.sv
mem_byte_lane.sv
mem_rsp_collect.sv
mem_dual_port.sv
mem_tb_assertions.sv
mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the mem_tb simulation with Verilator.
# Exit status is 0 only when the run reports a pass.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=mem_tb_sim

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module mem_tb \
  -f project.f \
  -Mdir "$BUILD_DIR" \
  -o "$SIM_BIN" > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "run_sim: verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
  echo "run_sim: simulation exited with status $status"
  exit 1
fi

if grep -q -F '*** TEST FAILED ***' "$SIM_LOG"; then
  echo "run_sim: testbench reported failure"
  exit 1
fi

if ! grep -q -F '*** TEST PASSED ***' "$SIM_LOG"; then
  echo "run_sim: no result line in $SIM_LOG"
  exit 1
fi

echo "run_sim: simulation passed"
exit 0
